//--- bridge_cfg_pkg.sv
/*
 * bridge port arrangement
 * number of ethernet lanes and width of the port select
 */
package bridge_cfg_pkg;

    // ----------------------------------------
    // lane arrangement
    // ----------------------------------------
    localparam int ETH_COUNT = 4;     // ethernet lanes behind the link

    // one lane attached to the link at a time
    localparam int PORT_SEL_W = 2;    // enough for ETH_COUNT lanes

endpackage

//--- frame_pkg.sv
/*
 * frame format and buffering constants
 */
package frame_pkg;

    localparam int BYTE_W = 8;        // stream byte width

    // leading bytes removed from every frame received from a MAC
    localparam int HDR_BYTES = 12;

    // ----------------------------------------
    // buffering
    // ----------------------------------------
    localparam int FIFO_DEPTH = 64;   // power of two
    localparam int MAX_FRAME  = 30;   // longest frame held, FIFO_DEPTH >= 2x this

endpackage

//--- byte_stream_if.sv
/*
 * byte stream with last flag and ready back-pressure
 */
`timescale 1ns/1ps

interface byte_stream_if;
    import frame_pkg::*;

    logic [BYTE_W-1:0] data;
    logic              valid;
    logic              last;      // final byte of a frame
    logic              ready;

    // a byte moves on a clock edge with valid and ready both high
    modport src (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport snk (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

//--- frame_fifo.sv
/*
 * synchronous byte FIFO keeping the last flag per byte
 * counts whole frames stored so a reader can wait for a complete frame
 */
`timescale 1ns/1ps

module frame_fifo (
    input  logic       clk125M,
    input  logic       rst_n_i,
    input  logic       flush_i,
    byte_stream_if.snk wr,
    byte_stream_if.src rd,
    output logic       frame_avail_o
);
    import frame_pkg::*;

    logic [BYTE_W:0]               mem [FIFO_DEPTH];    // {last, data}
    logic [$clog2(FIFO_DEPTH):0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH):0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   fill;
    logic [$clog2(FIFO_DEPTH):0]   frame_cnt;
    logic                          wr_fire;
    logic                          rd_fire;

    assign fill = wr_ptr - rd_ptr;    // pointers carry one extra wrap bit

    assign wr.ready = (fill != FIFO_DEPTH);
    assign rd.valid = (fill != '0);
    assign {rd.last, rd.data} = mem[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];   // show-ahead

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    assign frame_avail_o = (frame_cnt != '0);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk125M) begin
        if (wr_fire) begin
            mem[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= {wr.last, wr.data};
        end
    end

    // ----------------------------------------
    // pointers and frame count
    // ----------------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a frame counts once its last byte is in and until it is read out
            case ({wr_fire && wr.last, rd_fire && rd.last})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

//--- link_demux.sv
/*
 * lane enable decode and link receive routing
 * the registered link byte goes only to the enabled lane
 */
`timescale 1ns/1ps

module link_demux (
    input  logic                                  clk125M,
    input  logic                                  rst_n_i,
    input  logic                                  module_en_i,
    input  logic [bridge_cfg_pkg::PORT_SEL_W-1:0] port_sel_i,
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0]  mac_link_i,
    input  logic                                  chan_up_i,
    input  logic [frame_pkg::BYTE_W-1:0]          link_rx_data_i,
    input  logic                                  link_rx_valid_i,
    input  logic                                  link_rx_last_i,
    byte_stream_if.src                            lane_tx [bridge_cfg_pkg::ETH_COUNT],
    output logic [bridge_cfg_pkg::ETH_COUNT-1:0]  lane_en_o
);
    import bridge_cfg_pkg::*;
    import frame_pkg::*;

    logic [BYTE_W-1:0] rx_data_q;
    logic              rx_valid_q;
    logic              rx_last_q;

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            lane_en_o  <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            for (int k = 0; k < ETH_COUNT; k++) begin
                lane_en_o[k] <= module_en_i && (port_sel_i == PORT_SEL_W'(k)) &&
                                mac_link_i[k] && chan_up_i;   // one-hot by the select
            end
            rx_valid_q <= link_rx_valid_i;
        end
    end

    always_ff @(posedge clk125M) begin
        rx_data_q <= link_rx_data_i;
        rx_last_q <= link_rx_last_i;
    end

    // link has no back-pressure so a full or disabled lane loses the byte
    for (genvar k = 0; k < ETH_COUNT; k++) begin : g_lane
        assign lane_tx[k].data  = rx_data_q;
        assign lane_tx[k].last  = rx_last_q;
        assign lane_tx[k].valid = rx_valid_q && lane_en_o[k];
    end

endmodule

//--- mac_tx_sequencer.sv
/*
 * four-phase req/ack hand-off of one stored frame to the MAC
 */
`timescale 1ns/1ps

module mac_tx_sequencer (
    input  logic                         clk125M,
    input  logic                         rst_n_i,
    byte_stream_if.snk                   fifo,
    input  logic                         frame_avail_i,
    output logic                         mac_tx_req_o,
    input  logic                         mac_tx_ack_i,
    output logic [frame_pkg::BYTE_W-1:0] mac_tx_data_o,
    output logic                         mac_tx_valid_o,
    output logic                         mac_tx_sof_o,
    output logic                         mac_tx_eof_o
);

    enum logic [1:0] {S_IDLE, S_REQ, S_SEND, S_WAIT_ACK_LOW} state;

    logic rd_fire;
    logic rd_q;     // read in the previous cycle

    // stop reading once the last byte sits in the output register
    assign fifo.ready = (state == S_SEND) && !mac_tx_eof_o;
    assign rd_fire    = fifo.valid && fifo.ready;

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            state          <= S_IDLE;
            mac_tx_req_o   <= 1'b0;
            mac_tx_valid_o <= 1'b0;
            mac_tx_sof_o   <= 1'b0;
            mac_tx_eof_o   <= 1'b0;
            rd_q           <= 1'b0;
        end else begin
            rd_q           <= rd_fire;
            mac_tx_valid_o <= rd_fire;
            mac_tx_sof_o   <= rd_fire && !rd_q;         // first read of the burst
            mac_tx_eof_o   <= rd_fire && fifo.last;
            case (state)
                S_IDLE: begin
                    if (frame_avail_i && !mac_tx_ack_i) begin
                        mac_tx_req_o <= 1'b1;
                        state        <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mac_tx_ack_i) begin
                        state <= S_SEND;
                    end
                end
                S_SEND: begin
                    // empty FIFO here only after a flush
                    if (mac_tx_eof_o || !fifo.valid) begin
                        mac_tx_req_o <= 1'b0;
                        state        <= S_WAIT_ACK_LOW;
                    end
                end
                default: begin
                    if (!mac_tx_ack_i) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk125M) begin
        if (rd_fire) begin
            mac_tx_data_o <= fifo.data;
        end
    end

endmodule

//--- eth_lane.sv
/*
 * one ethernet lane
 * link bytes queue for the MAC, MAC frames lose their header and queue for the link
 */
`timescale 1ns/1ps

module eth_lane (
    input  logic                         clk125M,
    input  logic                         rst_n_i,
    input  logic                         lane_en_i,
    byte_stream_if.snk                   tx_in,
    byte_stream_if.src                   rx_out,
    output logic                         mac_tx_req_o,
    input  logic                         mac_tx_ack_i,
    output logic [frame_pkg::BYTE_W-1:0] mac_tx_data_o,
    output logic                         mac_tx_valid_o,
    output logic                         mac_tx_sof_o,
    output logic                         mac_tx_eof_o,
    input  logic [frame_pkg::BYTE_W-1:0] mac_rx_data_i,
    input  logic                         mac_rx_den_i,
    input  logic                         mac_rx_eof_i
);
    import frame_pkg::*;

    logic                           flush;
    logic                           tx_avail;
    logic [$clog2(HDR_BYTES+1)-1:0] hdr_cnt;    // saturates at HDR_BYTES

    byte_stream_if tx_rd ();
    byte_stream_if rx_wr ();

    assign flush = !lane_en_i;    // idle lane keeps both FIFOs empty

    // ----------------------------------------
    // MAC receive header cut
    // ----------------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            hdr_cnt     <= '0;
            rx_wr.valid <= 1'b0;
        end else begin
            rx_wr.valid <= lane_en_i && mac_rx_den_i && (hdr_cnt == HDR_BYTES);
            if (!mac_rx_den_i || mac_rx_eof_i) begin
                hdr_cnt <= '0;      // next burst starts a new frame
            end else if (hdr_cnt != HDR_BYTES) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk125M) begin
        rx_wr.data <= mac_rx_data_i;
        rx_wr.last <= mac_rx_eof_i;
    end

    // ----------------------------------------
    // frame buffers
    // ----------------------------------------
    // FIFO_DEPTH of at least 2x MAX_FRAME holds one frame while the next arrives
    frame_fifo u_tx_fifo (
        .clk125M       (clk125M),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush),
        .wr            (tx_in),
        .rd            (tx_rd),
        .frame_avail_o (tx_avail)
    );

    frame_fifo u_rx_fifo (
        .clk125M       (clk125M),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush),
        .wr            (rx_wr),
        .rd            (rx_out),
        .frame_avail_o ()          // link side drains bytes as they come
    );

    mac_tx_sequencer u_tx_seq (
        .clk125M        (clk125M),
        .rst_n_i        (rst_n_i),
        .fifo           (tx_rd),
        .frame_avail_i  (tx_avail),
        .mac_tx_req_o   (mac_tx_req_o),
        .mac_tx_ack_i   (mac_tx_ack_i),
        .mac_tx_data_o  (mac_tx_data_o),
        .mac_tx_valid_o (mac_tx_valid_o),
        .mac_tx_sof_o   (mac_tx_sof_o),
        .mac_tx_eof_o   (mac_tx_eof_o)
    );

endmodule

//--- link_mux.sv
/*
 * drains the enabled lane's receive FIFO onto the link transmit output
 */
`timescale 1ns/1ps

module link_mux (
    input  logic                                 clk125M,
    input  logic                                 rst_n_i,
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0] lane_en_i,
    byte_stream_if.snk                           lane_rx [bridge_cfg_pkg::ETH_COUNT],
    output logic [frame_pkg::BYTE_W-1:0]         link_tx_data_o,
    output logic                                 link_tx_valid_o,
    output logic                                 link_tx_last_o,
    input  logic                                 link_tx_ready_i
);
    import bridge_cfg_pkg::*;
    import frame_pkg::*;

    logic [BYTE_W-1:0]    lane_data [ETH_COUNT];
    logic [ETH_COUNT-1:0] lane_valid;
    logic [ETH_COUNT-1:0] lane_last;
    logic [BYTE_W-1:0]    sel_data;
    logic                 stage_ready;

    // output register may load when empty or being taken this cycle
    assign stage_ready = !link_tx_valid_o || link_tx_ready_i;

    for (genvar k = 0; k < ETH_COUNT; k++) begin : g_lane
        assign lane_data[k]     = lane_rx[k].data;
        assign lane_valid[k]    = lane_rx[k].valid;
        assign lane_last[k]     = lane_rx[k].last;
        assign lane_rx[k].ready = lane_en_i[k] && stage_ready;
    end

    always_comb begin
        sel_data = '0;
        for (int k = 0; k < ETH_COUNT; k++) begin
            sel_data = sel_data | (lane_data[k] & {BYTE_W{lane_en_i[k]}});  // one-hot or
        end
    end

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            link_tx_valid_o <= 1'b0;
        end else if (stage_ready) begin
            link_tx_valid_o <= |(lane_valid & lane_en_i);
        end
    end

    // held steady through a stall
    always_ff @(posedge clk125M) begin
        if (stage_ready && |(lane_valid & lane_en_i)) begin
            link_tx_data_o <= sel_data;
            link_tx_last_o <= |(lane_last & lane_en_i);
        end
    end

endmodule

//--- eth_link_bridge.sv
/*
 * ethernet to serial link port bridge
 * the selected lane exchanges frames with the link
 */
`timescale 1ns/1ps

module eth_link_bridge (
    input  logic                                                   clk125M,
    input  logic                                                   rst_n_i,
    // link side
    input  logic [frame_pkg::BYTE_W-1:0]                           link_rx_data_i,
    input  logic                                                   link_rx_valid_i,
    input  logic                                                   link_rx_last_i,
    output logic [frame_pkg::BYTE_W-1:0]                           link_tx_data_o,
    output logic                                                   link_tx_valid_o,
    output logic                                                   link_tx_last_o,
    input  logic                                                   link_tx_ready_i,
    // MAC side, one slice per lane
    output logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_tx_req_o,
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_tx_ack_i,
    output logic [bridge_cfg_pkg::ETH_COUNT*frame_pkg::BYTE_W-1:0] mac_tx_data_o,
    output logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_tx_valid_o,
    output logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_tx_sof_o,
    output logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_tx_eof_o,
    input  logic [bridge_cfg_pkg::ETH_COUNT*frame_pkg::BYTE_W-1:0] mac_rx_data_i,
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_rx_den_i,
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_rx_eof_i,
    // status
    input  logic [bridge_cfg_pkg::ETH_COUNT-1:0]                   mac_link_i,
    input  logic                                                   chan_up_i,
    input  logic                                                   module_en_i,
    input  logic [bridge_cfg_pkg::PORT_SEL_W-1:0]                  port_sel_i
);
    import bridge_cfg_pkg::*;
    import frame_pkg::*;

    logic [ETH_COUNT-1:0] lane_en;

    byte_stream_if lane_tx_if [ETH_COUNT] ();   // link toward lanes
    byte_stream_if lane_rx_if [ETH_COUNT] ();   // lanes toward link

    link_demux u_demux (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n_i),
        .module_en_i     (module_en_i),
        .port_sel_i      (port_sel_i),
        .mac_link_i      (mac_link_i),
        .chan_up_i       (chan_up_i),
        .link_rx_data_i  (link_rx_data_i),
        .link_rx_valid_i (link_rx_valid_i),
        .link_rx_last_i  (link_rx_last_i),
        .lane_tx         (lane_tx_if),
        .lane_en_o       (lane_en)
    );

    for (genvar k = 0; k < ETH_COUNT; k++) begin : lane
        eth_lane u_lane (
            .clk125M        (clk125M),
            .rst_n_i        (rst_n_i),
            .lane_en_i      (lane_en[k]),
            .tx_in          (lane_tx_if[k]),
            .rx_out         (lane_rx_if[k]),
            .mac_tx_req_o   (mac_tx_req_o[k]),
            .mac_tx_ack_i   (mac_tx_ack_i[k]),
            .mac_tx_data_o  (mac_tx_data_o[k*BYTE_W +: BYTE_W]),
            .mac_tx_valid_o (mac_tx_valid_o[k]),
            .mac_tx_sof_o   (mac_tx_sof_o[k]),
            .mac_tx_eof_o   (mac_tx_eof_o[k]),
            .mac_rx_data_i  (mac_rx_data_i[k*BYTE_W +: BYTE_W]),
            .mac_rx_den_i   (mac_rx_den_i[k]),
            .mac_rx_eof_i   (mac_rx_eof_i[k])
        );
    end

    link_mux u_mux (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n_i),
        .lane_en_i       (lane_en),
        .lane_rx         (lane_rx_if),
        .link_tx_data_o  (link_tx_data_o),
        .link_tx_valid_o (link_tx_valid_o),
        .link_tx_last_o  (link_tx_last_o),
        .link_tx_ready_i (link_tx_ready_i)
    );

endmodule

//--- tb_eth_link_bridge.sv
/*
 * testbench for the ethernet to serial link bridge
 * MAC and link models around the DUT, checks by immediate assertions
 */
`timescale 1ns/1ps

module tb_eth_link_bridge;
    import bridge_cfg_pkg::*;
    import frame_pkg::*;

    localparam int ACK_MAX        = 5;     // MAC ack delay range in cycles
    localparam int SETTLE_CYCLES  = 40;    // quiet time to catch stray output
    localparam int N_FRAMES       = 24;    // frames sent over all tests, rounded up
    localparam int TIMEOUT_CYCLES =
        2 * (N_FRAMES * (MAX_FRAME + 2 * ACK_MAX + 8) + 8 * SETTLE_CYCLES);

    logic                          clk125M;
    logic                          rst_n;
    logic [BYTE_W-1:0]             link_rx_data;
    logic                          link_rx_valid;
    logic                          link_rx_last;
    logic [BYTE_W-1:0]             link_tx_data;
    logic                          link_tx_valid;
    logic                          link_tx_last;
    logic                          link_tx_ready;
    logic [ETH_COUNT-1:0]          mac_tx_req;
    logic [ETH_COUNT-1:0]          mac_tx_ack;
    logic [ETH_COUNT*BYTE_W-1:0]   mac_tx_data;
    logic [ETH_COUNT-1:0]          mac_tx_valid;
    logic [ETH_COUNT-1:0]          mac_tx_sof;
    logic [ETH_COUNT-1:0]          mac_tx_eof;
    logic [ETH_COUNT*BYTE_W-1:0]   mac_rx_data;
    logic [ETH_COUNT-1:0]          mac_rx_den;
    logic [ETH_COUNT-1:0]          mac_rx_eof;
    logic [ETH_COUNT-1:0]          mac_link;
    logic                          chan_up;
    logic                          module_en;
    logic [PORT_SEL_W-1:0]         port_sel;

    integer               seed = 32'h4732;
    int                   fail_cnt;
    int                   phase_errs;
    int                   tests_passed;
    int                   tests_failed;
    int                   cycle_cnt;
    logic [ETH_COUNT-1:0] req_allowed;     // lanes that may request the MAC
    logic                 link_allowed;
    logic                 bp_mode;         // random link ready
    logic [BYTE_W:0]      mac_exp [$];     // {last, data} expected on MAC transmit
    logic [BYTE_W:0]      link_exp [$];    // {last, data} expected on link transmit
    logic                 mac_ack [ETH_COUNT];

    eth_link_bridge u_dut (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n),
        .link_rx_data_i  (link_rx_data),
        .link_rx_valid_i (link_rx_valid),
        .link_rx_last_i  (link_rx_last),
        .link_tx_data_o  (link_tx_data),
        .link_tx_valid_o (link_tx_valid),
        .link_tx_last_o  (link_tx_last),
        .link_tx_ready_i (link_tx_ready),
        .mac_tx_req_o    (mac_tx_req),
        .mac_tx_ack_i    (mac_tx_ack),
        .mac_tx_data_o   (mac_tx_data),
        .mac_tx_valid_o  (mac_tx_valid),
        .mac_tx_sof_o    (mac_tx_sof),
        .mac_tx_eof_o    (mac_tx_eof),
        .mac_rx_data_i   (mac_rx_data),
        .mac_rx_den_i    (mac_rx_den),
        .mac_rx_eof_i    (mac_rx_eof),
        .mac_link_i      (mac_link),
        .chan_up_i       (chan_up),
        .module_en_i     (module_en),
        .port_sel_i      (port_sel)
    );

    initial clk125M = 1'b0;
    always #4 clk125M = ~clk125M;    // 125 MHz

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // lane runs when selected, enabled, link up and channel up
    function automatic bit lane_active(input int lane);
        return module_en && chan_up && mac_link[lane] && (port_sel == PORT_SEL_W'(lane));
    endfunction

    task automatic flag_error(input string msg);
        fail_cnt++;
        $display("[FAIL] %0t ns %s", $time, msg);
    endtask

    task automatic end_test(input string name, input bit ok);
        if (ok) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: errors found", name);
        end
    endtask

    task automatic set_config(input bit en, input bit chan, input logic [ETH_COUNT-1:0] links,
                              input int sel);
        @(posedge clk125M);
        module_en <= en;
        chan_up   <= chan;
        mac_link  <= links;
        port_sel  <= PORT_SEL_W'(sel);
        repeat (3) @(posedge clk125M);   // lane enable follows one cycle later
    endtask

    task automatic send_link_frame(input int len);
        int         i;
        logic [7:0] b;
        bit         active;
        active = lane_active(port_sel);
        for (i = 0; i < len; i++) begin
            b = rand_range(0, 255);
            @(posedge clk125M);
            link_rx_data  <= b;
            link_rx_valid <= 1'b1;
            link_rx_last  <= (i == len - 1);
            if (active) begin
                mac_exp.push_back({i == len - 1, b});
            end
        end
        @(posedge clk125M);
        link_rx_valid <= 1'b0;
        link_rx_last  <= 1'b0;
    endtask

    task automatic send_mac_frame(input int lane, input int len);
        int         i;
        logic [7:0] b;
        bit         active;
        active = lane_active(lane);
        for (i = 0; i < len; i++) begin
            b = rand_range(0, 255);
            @(posedge clk125M);
            mac_rx_data[lane*BYTE_W +: BYTE_W] <= b;
            mac_rx_den[lane] <= 1'b1;
            mac_rx_eof[lane] <= (i == len - 1);
            if (active && i >= HDR_BYTES) begin   // header bytes are cut
                link_exp.push_back({i == len - 1, b});
            end
        end
        @(posedge clk125M);
        mac_rx_den[lane] <= 1'b0;
        mac_rx_eof[lane] <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk125M);
        while (mac_exp.size() != 0 || link_exp.size() != 0 ||
               mac_tx_req !== '0 || mac_tx_ack !== '0) begin
            @(posedge clk125M);
        end
    endtask

    task automatic check_idle_outputs();
        assert (mac_tx_req === '0 && mac_tx_valid === '0 && link_tx_valid === 1'b0)
            else flag_error("outputs not low around reset");
    endtask

    // ----------------------------------------
    // MAC models, one per lane
    // ----------------------------------------
    for (genvar k = 0; k < ETH_COUNT; k++) begin : mac_model
        assign mac_tx_ack[k] = mac_ack[k];

        initial begin
            int dly;
            mac_ack[k] = 1'b0;
            forever begin
                @(posedge clk125M);
                if (mac_tx_req[k] === 1'b1 && !mac_ack[k]) begin
                    dly = rand_range(0, ACK_MAX);
                    repeat (dly) @(posedge clk125M);
                    mac_ack[k] <= 1'b1;
                    @(posedge clk125M);
                    while (!(mac_tx_valid[k] && mac_tx_eof[k])) @(posedge clk125M);
                    dly = rand_range(0, ACK_MAX);
                    repeat (dly) @(posedge clk125M);
                    mac_ack[k] <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk125M) begin
        link_tx_ready <= bp_mode ? (rand_range(0, 1) == 1) : 1'b1;
    end

    // ----------------------------------------
    // checkers
    // ----------------------------------------
    // MAC transmit bytes against the expected queue
    always @(posedge clk125M) begin
        int              k;
        logic [BYTE_W:0] exp_b;
        bit              first;
        if (!rst_n) begin
            first = 1'b1;
        end else begin
            for (k = 0; k < ETH_COUNT; k++) begin
                assert (!mac_tx_valid[k] || req_allowed[k])
                    else flag_error($sformatf("lane %0d sent a byte while not allowed", k));
                if (mac_tx_valid[k] && mac_exp.size() == 0) begin
                    flag_error($sformatf("lane %0d sent an unexpected byte", k));
                end else if (mac_tx_valid[k]) begin
                    exp_b = mac_exp.pop_front();
                    assert (mac_tx_data[k*BYTE_W +: BYTE_W] === exp_b[BYTE_W-1:0])
                        else flag_error($sformatf("lane %0d data %h, expected %h", k,
                                        mac_tx_data[k*BYTE_W +: BYTE_W], exp_b[BYTE_W-1:0]));
                    assert (mac_tx_sof[k] === first)
                        else flag_error($sformatf("lane %0d sof wrong", k));
                    assert (mac_tx_eof[k] === exp_b[BYTE_W])
                        else flag_error($sformatf("lane %0d eof wrong", k));
                    first = exp_b[BYTE_W];    // next byte opens a frame
                end
            end
        end
    end

    // four-phase req/ack rule on every lane
    always @(posedge clk125M) begin
        int                   k;
        logic [ETH_COUNT-1:0] req_q;
        logic [ETH_COUNT-1:0] ack_q;
        logic [ETH_COUNT-1:0] eof_seen;
        if (rst_n) begin
            for (k = 0; k < ETH_COUNT; k++) begin
                assert (!mac_tx_valid[k] || mac_tx_ack[k]) else begin
                    phase_errs++;
                    flag_error($sformatf("lane %0d valid without ack", k));
                end
                assert (!(mac_tx_req[k] && !req_q[k]) || !ack_q[k]) else begin
                    phase_errs++;
                    flag_error($sformatf("lane %0d req rose while ack high", k));
                end
                assert (!(!mac_tx_req[k] && req_q[k]) || eof_seen[k]) else begin
                    phase_errs++;
                    flag_error($sformatf("lane %0d req fell before eof", k));
                end
                assert (!mac_tx_req[k] || req_allowed[k])
                    else flag_error($sformatf("lane %0d raised req while not allowed", k));
            end
        end
        eof_seen = (eof_seen & ~(mac_tx_req & ~req_q)) | mac_tx_eof;
        req_q    = mac_tx_req;
        ack_q    = mac_tx_ack;
    end

    // link transmit payload and stall stability
    always @(posedge clk125M) begin
        logic [BYTE_W:0]   exp_b;
        logic              stall_q;
        logic [BYTE_W-1:0] data_q;
        logic              last_q;
        if (rst_n) begin
            assert (!link_tx_valid || link_allowed)
                else flag_error("link transmit valid while not allowed");
            assert (!stall_q || (link_tx_valid && link_tx_data === data_q &&
                                 link_tx_last === last_q))
                else flag_error("link transmit changed during a stall");
            if (link_tx_valid && link_tx_ready && link_exp.size() == 0) begin
                flag_error("unexpected byte on link transmit");
            end else if (link_tx_valid && link_tx_ready) begin
                exp_b = link_exp.pop_front();
                assert ({link_tx_last, link_tx_data} === exp_b)
                    else flag_error($sformatf("link byte %h last %b, expected %h last %b",
                                    link_tx_data, link_tx_last, exp_b[BYTE_W-1:0],
                                    exp_b[BYTE_W]));
            end
        end
        stall_q = rst_n && link_tx_valid && !link_tx_ready;
        data_q  = link_tx_data;
        last_q  = link_tx_last;
    end

    always @(posedge clk125M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, frames were not delivered", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int errs;
        int k;
        int g;
        rst_n         = 1'b0;
        link_rx_data  = '0;
        link_rx_valid = 1'b0;
        link_rx_last  = 1'b0;
        link_tx_ready = 1'b1;
        mac_rx_data   = '0;
        mac_rx_den    = '0;
        mac_rx_eof    = '0;
        mac_link      = '0;
        chan_up       = 1'b0;
        module_en     = 1'b0;
        port_sel      = '0;
        fail_cnt      = 0;
        phase_errs    = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycle_cnt     = 0;
        req_allowed   = '0;
        link_allowed  = 1'b0;
        bp_mode       = 1'b0;

        // reset values, checked during reset and just after
        errs = fail_cnt;
        @(posedge clk125M);
        repeat (4) begin
            @(posedge clk125M);
            check_idle_outputs();
        end
        rst_n <= 1'b1;
        repeat (2) begin
            @(posedge clk125M);
            check_idle_outputs();
        end
        end_test("reset values", fail_cnt == errs);

        // link to MAC on each lane
        errs = fail_cnt;
        for (k = 0; k < ETH_COUNT; k++) begin
            set_config(1'b1, 1'b1, '1, k);
            req_allowed <= ETH_COUNT'(1) << k;
            repeat (2) send_link_frame(rand_range(1, MAX_FRAME - 1));
            wait_idle();
        end
        end_test("link to MAC transfer", fail_cnt == errs);

        // header cut, lane 1 selected
        errs = fail_cnt;
        req_allowed <= '0;
        set_config(1'b1, 1'b1, '1, 1);
        link_allowed <= 1'b1;
        send_mac_frame(1, HDR_BYTES);
        send_mac_frame(1, HDR_BYTES - 4);
        send_mac_frame(1, HDR_BYTES + 1);
        send_mac_frame(1, rand_range(HDR_BYTES + 2, MAX_FRAME - 1));
        send_mac_frame(3, MAX_FRAME - 1);     // unselected lane
        wait_idle();
        repeat (SETTLE_CYCLES) @(posedge clk125M);
        end_test("header cut", fail_cnt == errs);

        // gating by module enable, MAC link and channel
        errs = fail_cnt;
        link_allowed <= 1'b0;
        for (g = 0; g < 3; g++) begin
            set_config(g != 0, g != 2, (g == 1) ? 4'b1011 : 4'b1111, 2);
            send_link_frame(20);
            send_mac_frame(2, 20);
            wait_idle();
            repeat (SETTLE_CYCLES) @(posedge clk125M);
        end
        end_test("gating", fail_cnt == errs);

        // back-pressure on link transmit
        errs = fail_cnt;
        set_config(1'b1, 1'b1, '1, 2);
        link_allowed <= 1'b1;
        bp_mode      <= 1'b1;
        repeat (3) send_mac_frame(2, rand_range(HDR_BYTES + 1, MAX_FRAME - 1));
        wait_idle();
        bp_mode <= 1'b0;
        repeat (SETTLE_CYCLES) @(posedge clk125M);
        end_test("back-pressure", fail_cnt == errs);

        end_test("four-phase rule", phase_errs == 0);

        $display("%0d tests passed, %0d tests failed, %0d checks failed",
                 tests_passed, tests_failed, fail_cnt);
        if (fail_cnt == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
bridge_cfg_pkg.sv
frame_pkg.sv
byte_stream_if.sv
frame_fifo.sv
link_demux.sv
mac_tx_sequencer.sv
eth_lane.sv
link_mux.sv
eth_link_bridge.sv
tb_eth_link_bridge.sv
